//--- Makefile
TOP := tb_id_stage

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)
	verilator --lint-only --timing --assert -f project.f --top-module id_stage

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- common/isa_pkg.sv
`default_nettype none

package isa_pkg;

    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;

    typedef logic [4:0]      reg_idx_t;
    typedef logic [XLEN-1:0] word_t;

    // One-hot ALU operation.
    typedef logic [11:0] alu_op_t;

    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    typedef struct packed {
        logic [16:0] op17;
        reg_idx_t    rk;
        reg_idx_t    rj;
        reg_idx_t    rd;
    } fmt_3r_t;

    typedef struct packed {
        logic [9:0]  op22;   // Major opcode, bits 31:22.
        logic [11:0] i12;
        reg_idx_t    rj;
        reg_idx_t    rd;
    } fmt_2ri12_t;

    typedef struct packed {
        logic [5:0]  op6;
        logic [15:0] i16;
        reg_idx_t    rj;
        reg_idx_t    rd;
    } fmt_2ri16_t;

    typedef struct packed {
        logic [6:0]  op7;
        logic [19:0] i20;
        reg_idx_t    rd;
    } fmt_1ri20_t;

    typedef struct packed {
        logic [5:0]  op6;
        logic [15:0] offs_lo;
        logic [9:0]  offs_hi;
    } fmt_i26_t;

    typedef union packed {
        fmt_3r_t    fmt_3r;
        fmt_2ri12_t fmt_2ri12;
        fmt_2ri16_t fmt_2ri16;
        fmt_1ri20_t fmt_1ri20;
        fmt_i26_t   fmt_i26;
    } inst_word_u;

    localparam logic [5:0] OP6_BRANCH_JIRL = 6'h13;
    localparam logic [5:0] OP6_BRANCH_B    = 6'h14;
    localparam logic [5:0] OP6_BRANCH_BL   = 6'h15;
    localparam logic [5:0] OP6_BRANCH_BEQ  = 6'h16;
    localparam logic [5:0] OP6_BRANCH_BNE  = 6'h17;
    localparam logic [5:0] OP6_BRANCH_BLT  = 6'h18;
    localparam logic [5:0] OP6_BRANCH_BGE  = 6'h19;
    localparam logic [5:0] OP6_BRANCH_BLTU = 6'h1a;
    localparam logic [5:0] OP6_BRANCH_BGEU = 6'h1b;

    localparam logic [9:0] OP10_SLTI   = 10'h008;
    localparam logic [9:0] OP10_SLTUI  = 10'h009;
    localparam logic [9:0] OP10_ADDI_W = 10'h00a;
    localparam logic [9:0] OP10_ANDI   = 10'h00d;
    localparam logic [9:0] OP10_ORI    = 10'h00e;
    localparam logic [9:0] OP10_XORI   = 10'h00f;
    localparam logic [9:0] OP10_LD_B   = 10'h0a0;
    localparam logic [9:0] OP10_LD_H   = 10'h0a1;
    localparam logic [9:0] OP10_LD_W   = 10'h0a2;
    localparam logic [9:0] OP10_ST_B   = 10'h0a4;
    localparam logic [9:0] OP10_ST_H   = 10'h0a5;
    localparam logic [9:0] OP10_ST_W   = 10'h0a6;
    localparam logic [9:0] OP10_LD_BU  = 10'h0a8;
    localparam logic [9:0] OP10_LD_HU  = 10'h0a9;

    localparam logic [16:0] OP17_ADD_W  = 17'h00020;
    localparam logic [16:0] OP17_SUB_W  = 17'h00022;
    localparam logic [16:0] OP17_SLT    = 17'h00024;
    localparam logic [16:0] OP17_SLTU   = 17'h00025;
    localparam logic [16:0] OP17_NOR    = 17'h00028;
    localparam logic [16:0] OP17_AND    = 17'h00029;
    localparam logic [16:0] OP17_OR     = 17'h0002a;
    localparam logic [16:0] OP17_XOR    = 17'h0002b;
    localparam logic [16:0] OP17_SLL_W  = 17'h0002e;
    localparam logic [16:0] OP17_SRL_W  = 17'h0002f;
    localparam logic [16:0] OP17_SRA_W  = 17'h00030;
    localparam logic [16:0] OP17_SLLI_W = 17'h00081;
    localparam logic [16:0] OP17_SRLI_W = 17'h00089;
    localparam logic [16:0] OP17_SRAI_W = 17'h00091;

    localparam logic [6:0] OP7_LU12I     = 7'h0a;
    localparam logic [6:0] OP7_PCADDU12I = 7'h0e;

    // Branch kind handed from the decoder to the branch unit.
    typedef logic [3:0] br_kind_t;

    localparam br_kind_t BR_NONE = 4'd0;
    localparam br_kind_t BR_JIRL = 4'd1;
    localparam br_kind_t BR_B    = 4'd2;
    localparam br_kind_t BR_BL   = 4'd3;
    localparam br_kind_t BR_BEQ  = 4'd4;
    localparam br_kind_t BR_BNE  = 4'd5;
    localparam br_kind_t BR_BLT  = 4'd6;
    localparam br_kind_t BR_BGE  = 4'd7;
    localparam br_kind_t BR_BLTU = 4'd8;
    localparam br_kind_t BR_BGEU = 4'd9;

endpackage

`default_nettype wire

//--- common/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    import isa_pkg::*;

    typedef struct packed {
        word_t      pc;
        inst_word_u inst;
    } if_id_t;

    typedef struct packed {
        logic     we;
        reg_idx_t addr;
        word_t    data;
    } wb_rf_t;

    // Result of a later stage, dest of zero when it writes nothing.
    typedef struct packed {
        reg_idx_t dest;
        word_t    value;
    } fwd_src_t;

    typedef struct packed {
        alu_op_t    alu_op;
        logic       src1_is_pc;
        logic       src2_is_imm;
        logic       load_op;
        logic       store_op;
        logic [3:0] mem_we;
        logic       mem_is_byte;
        logic       mem_is_half;
        logic       mem_is_word;
        logic       src_is_signed;
        logic       gr_we;
        reg_idx_t   dest;
        logic       illegal;
    } ctrl_t;

    typedef struct packed {
        ctrl_t ctrl;
        word_t pc;
        word_t imm;
        word_t rj_value;
        word_t rkd_value;
    } id_ex_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } br_t;

endpackage

`default_nettype wire

//--- decode/id_stage.sv
`timescale 1ns/10ps
`default_nettype none

module id_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  wire           clk,
    input  wire           reset,
    input  wire           if_valid,
    input  wire if_id_t   if_id,
    output logic          id_allow_in,
    output logic          id_ex_valid,
    output id_ex_t        id_ex,
    input  wire           ex_allow_in,
    input  wire fwd_src_t ex_fwd,
    input  wire fwd_src_t me_fwd,
    input  wire fwd_src_t wb_fwd,
    input  wire           ex_is_load,
    input  wire wb_rf_t   wb_rf,
    output br_t           br
);

    logic     id_valid;
    if_id_t   id_r;
    logic     id_to_ex;
    ctrl_t    ctrl;
    word_t    imm;
    word_t    br_offs;
    logic     use_rj, use_rk, use_rd;
    reg_idx_t rj, rk, rd;
    br_kind_t br_kind;
    word_t    rf_rdata1, rf_rdata2;
    reg_idx_t rf_raddr2;
    word_t    rj_value, rkd_value;
    logic     ld_stall;
    logic     cond_taken;
    word_t    br_target;

    assign id_ex_valid = id_valid && !ld_stall;
    assign id_to_ex    = id_ex_valid && ex_allow_in;
    assign id_allow_in = !id_valid || id_to_ex;

    // A taken branch also drops whatever fetch delivers behind it.
    always_ff @(posedge clk) begin
        if (reset || br.taken) begin
            id_valid <= 1'b0;
        end else if (id_allow_in) begin
            id_valid <= if_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (if_valid && id_allow_in) begin
            id_r <= if_id;
        end
    end

    inst_decoder inst_decoder_i (
        .inst    (id_r.inst),
        .ctrl    (ctrl),
        .imm     (imm),
        .br_offs (br_offs),
        .use_rj  (use_rj),
        .use_rk  (use_rk),
        .use_rd  (use_rd),
        .rj      (rj),
        .rk      (rk),
        .rd      (rd),
        .br_kind (br_kind)
    );

    regfile regfile_i (
        .clk    (clk),
        .reset  (reset),
        .raddr1 (rj),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .wr     (wb_rf)
    );

    operand_forward operand_forward_i (
        .rj         (rj),
        .rk         (rk),
        .rd         (rd),
        .use_rj     (use_rj),
        .use_rk     (use_rk),
        .use_rd     (use_rd),
        .rf_rdata1  (rf_rdata1),
        .rf_rdata2  (rf_rdata2),
        .ex_fwd     (ex_fwd),
        .me_fwd     (me_fwd),
        .wb_fwd     (wb_fwd),
        .ex_is_load (ex_is_load),
        .rj_value   (rj_value),
        .rkd_value  (rkd_value),
        .rf_raddr2  (rf_raddr2),
        .ld_stall   (ld_stall)
    );

    branch_unit branch_unit_i (
        .br_kind    (br_kind),
        .pc         (id_r.pc),
        .rj_value   (rj_value),
        .rkd_value  (rkd_value),
        .br_offs    (br_offs),
        .cond_taken (cond_taken),
        .target     (br_target)
    );

    assign br.taken  = id_to_ex && cond_taken;
    assign br.target = br_target;

    assign id_ex.ctrl      = ctrl;
    assign id_ex.pc        = id_r.pc;
    assign id_ex.imm       = imm;
    assign id_ex.rj_value  = rj_value;
    assign id_ex.rkd_value = rkd_value;

    // A stalled instruction stays in ID unchanged.
    hold_in_load_stall: assert property (@(posedge clk) disable iff (reset)
        id_valid && ld_stall |=> id_valid && $stable(id_r));

endmodule

`default_nettype wire

//--- decode/inst_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module inst_decoder
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  wire inst_word_u inst,
    output ctrl_t           ctrl,
    output word_t           imm,
    output word_t           br_offs,
    output logic            use_rj,
    output logic            use_rk,
    output logic            use_rd,
    output reg_idx_t        rj,
    output reg_idx_t        rk,
    output reg_idx_t        rd,
    output br_kind_t        br_kind
);

    logic [16:0] op17;
    logic [9:0]  op10;
    logic [11:0] i12;
    logic        i_add, i_sub, i_slt, i_sltu, i_nor, i_and, i_or, i_xor;
    logic        i_sll, i_srl, i_sra, i_slli, i_srli, i_srai;
    logic        i_addi, i_slti, i_sltui, i_andi, i_ori, i_xori;
    logic        i_lu12i, i_pcaddu12i;
    logic        i_ld_b, i_ld_h, i_ld_w, i_ld_bu, i_ld_hu;
    logic        i_st_b, i_st_h, i_st_w;
    logic        is_reg3r, is_shift_imm, is_load, is_store, is_br, is_cond_br;
    logic        inst_valid;
    alu_op_t     alu_op;
    logic [3:0]  mem_we;

    assign op17 = inst.fmt_3r.op17;
    assign op10 = inst.fmt_2ri12.op22;
    assign i12  = inst.fmt_2ri12.i12;

    assign rj = inst.fmt_3r.rj;
    assign rk = inst.fmt_3r.rk;
    assign rd = inst.fmt_3r.rd;

    assign i_add  = op17 == OP17_ADD_W;
    assign i_sub  = op17 == OP17_SUB_W;
    assign i_slt  = op17 == OP17_SLT;
    assign i_sltu = op17 == OP17_SLTU;
    assign i_nor  = op17 == OP17_NOR;
    assign i_and  = op17 == OP17_AND;
    assign i_or   = op17 == OP17_OR;
    assign i_xor  = op17 == OP17_XOR;
    assign i_sll  = op17 == OP17_SLL_W;
    assign i_srl  = op17 == OP17_SRL_W;
    assign i_sra  = op17 == OP17_SRA_W;
    assign i_slli = op17 == OP17_SLLI_W;
    assign i_srli = op17 == OP17_SRLI_W;
    assign i_srai = op17 == OP17_SRAI_W;

    assign i_addi  = op10 == OP10_ADDI_W;
    assign i_slti  = op10 == OP10_SLTI;
    assign i_sltui = op10 == OP10_SLTUI;
    assign i_andi  = op10 == OP10_ANDI;
    assign i_ori   = op10 == OP10_ORI;
    assign i_xori  = op10 == OP10_XORI;
    assign i_ld_b  = op10 == OP10_LD_B;
    assign i_ld_h  = op10 == OP10_LD_H;
    assign i_ld_w  = op10 == OP10_LD_W;
    assign i_ld_bu = op10 == OP10_LD_BU;
    assign i_ld_hu = op10 == OP10_LD_HU;
    assign i_st_b  = op10 == OP10_ST_B;
    assign i_st_h  = op10 == OP10_ST_H;
    assign i_st_w  = op10 == OP10_ST_W;

    assign i_lu12i     = inst.fmt_1ri20.op7 == OP7_LU12I;
    assign i_pcaddu12i = inst.fmt_1ri20.op7 == OP7_PCADDU12I;

    always_comb begin
        case (inst.fmt_2ri16.op6)
            OP6_BRANCH_JIRL: br_kind = BR_JIRL;
            OP6_BRANCH_B:    br_kind = BR_B;
            OP6_BRANCH_BL:   br_kind = BR_BL;
            OP6_BRANCH_BEQ:  br_kind = BR_BEQ;
            OP6_BRANCH_BNE:  br_kind = BR_BNE;
            OP6_BRANCH_BLT:  br_kind = BR_BLT;
            OP6_BRANCH_BGE:  br_kind = BR_BGE;
            OP6_BRANCH_BLTU: br_kind = BR_BLTU;
            OP6_BRANCH_BGEU: br_kind = BR_BGEU;
            default:         br_kind = BR_NONE;
        endcase
    end

    assign is_reg3r     = i_add | i_sub | i_slt | i_sltu | i_nor | i_and | i_or | i_xor |
                          i_sll | i_srl | i_sra;
    assign is_shift_imm = i_slli | i_srli | i_srai;
    assign is_load      = i_ld_b | i_ld_h | i_ld_w | i_ld_bu | i_ld_hu;
    assign is_store     = i_st_b | i_st_h | i_st_w;
    assign is_br        = br_kind != BR_NONE;
    assign is_cond_br   = br_kind >= BR_BEQ;

    assign inst_valid = is_reg3r | is_shift_imm | is_load | is_store | is_br |
                        i_addi | i_slti | i_sltui | i_andi | i_ori | i_xori |
                        i_lu12i | i_pcaddu12i;

    assign alu_op[ALU_ADD]  = i_add | i_addi | is_load | is_store | i_pcaddu12i |
                              br_kind == BR_JIRL | br_kind == BR_BL;   // Link adds pc + 4.
    assign alu_op[ALU_SUB]  = i_sub;
    assign alu_op[ALU_SLT]  = i_slt | i_slti;
    assign alu_op[ALU_SLTU] = i_sltu | i_sltui;
    assign alu_op[ALU_AND]  = i_and | i_andi;
    assign alu_op[ALU_NOR]  = i_nor;
    assign alu_op[ALU_OR]   = i_or | i_ori;
    assign alu_op[ALU_XOR]  = i_xor | i_xori;
    assign alu_op[ALU_SLL]  = i_sll | i_slli;
    assign alu_op[ALU_SRL]  = i_srl | i_srli;
    assign alu_op[ALU_SRA]  = i_sra | i_srai;
    assign alu_op[ALU_LUI]  = i_lu12i;

    assign mem_we = i_st_w ? 4'b1111 :
                    i_st_h ? 4'b0011 :
                    i_st_b ? 4'b0001 :
                             4'b0000;

    always_comb begin
        ctrl = '0;
        if (inst_valid) begin
            ctrl.alu_op        = alu_op;
            ctrl.src1_is_pc    = i_pcaddu12i | br_kind == BR_JIRL | br_kind == BR_BL;
            ctrl.src2_is_imm   = is_shift_imm | is_load | is_store | i_addi | i_slti |
                                 i_sltui | i_andi | i_ori | i_xori | i_lu12i | i_pcaddu12i |
                                 br_kind == BR_JIRL | br_kind == BR_BL;
            ctrl.load_op       = is_load;
            ctrl.store_op      = is_store;
            ctrl.mem_we        = mem_we;
            ctrl.mem_is_byte   = i_ld_b | i_ld_bu | i_st_b;
            ctrl.mem_is_half   = i_ld_h | i_ld_hu | i_st_h;
            ctrl.mem_is_word   = i_ld_w | i_st_w;
            ctrl.src_is_signed = i_ld_b | i_ld_h | br_kind == BR_BLT | br_kind == BR_BGE;
            ctrl.gr_we         = ~(is_store | is_cond_br | br_kind == BR_B);
            ctrl.dest          = (br_kind == BR_BL) ? 5'd1 : rd;
        end else begin
            ctrl.illegal = 1'b1;   // Bubble with no side effects.
        end
    end

    always_comb begin
        if (br_kind == BR_JIRL || br_kind == BR_BL) begin
            imm = 32'd4;
        end else if (i_lu12i || i_pcaddu12i) begin
            imm = {inst.fmt_1ri20.i20, 12'b0};
        end else if (is_shift_imm) begin
            imm = {27'b0, rk};
        end else if (i_andi || i_ori || i_xori) begin
            imm = {20'b0, i12};
        end else begin
            imm = {{20{i12[11]}}, i12};
        end
    end

    assign br_offs = (br_kind == BR_B || br_kind == BR_BL) ?
                     {{4{inst.fmt_i26.offs_hi[9]}}, inst.fmt_i26.offs_hi,
                      inst.fmt_i26.offs_lo, 2'b0} :
                     {{14{inst.fmt_2ri16.i16[15]}}, inst.fmt_2ri16.i16, 2'b0};

    assign use_rj = inst_valid & ~(i_lu12i | i_pcaddu12i | br_kind == BR_B | br_kind == BR_BL);
    assign use_rk = is_reg3r;
    assign use_rd = is_store | is_cond_br;

    // Byte mask follows the access size of a store.
    always_comb begin
        assert (ctrl.mem_we == (ctrl.store_op ?
                {{2{ctrl.mem_is_word}}, ctrl.mem_is_half | ctrl.mem_is_word, 1'b1} : 4'b0000))
            else $error("Bad store byte mask %b.", ctrl.mem_we);
    end

endmodule

`default_nettype wire

//--- hw/branch_unit.sv
`timescale 1ns/10ps
`default_nettype none

module branch_unit
    import isa_pkg::*;
(
    input  wire br_kind_t br_kind,
    input  wire word_t    pc,
    input  wire word_t    rj_value,
    input  wire word_t    rkd_value,
    input  wire word_t    br_offs,
    output logic          cond_taken,
    output word_t         target
);

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = rj_value == rkd_value;
    assign lt_s = $signed(rj_value) < $signed(rkd_value);
    assign lt_u = rj_value < rkd_value;

    always_comb begin
        case (br_kind)
            BR_JIRL, BR_B, BR_BL: cond_taken = 1'b1;
            BR_BEQ:               cond_taken = eq;
            BR_BNE:               cond_taken = !eq;
            BR_BLT:               cond_taken = lt_s;
            BR_BGE:               cond_taken = !lt_s;
            BR_BLTU:              cond_taken = lt_u;
            BR_BGEU:              cond_taken = !lt_u;
            default:              cond_taken = 1'b0;
        endcase
    end

    // jirl is register relative, the rest pc relative.
    assign target = ((br_kind == BR_JIRL) ? rj_value : pc) + br_offs;

endmodule

`default_nettype wire

//--- hw/operand_forward.sv
`timescale 1ns/10ps
`default_nettype none

module operand_forward
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  wire reg_idx_t rj,
    input  wire reg_idx_t rk,
    input  wire reg_idx_t rd,
    input  wire           use_rj,
    input  wire           use_rk,
    input  wire           use_rd,
    input  wire word_t    rf_rdata1,
    input  wire word_t    rf_rdata2,
    input  wire fwd_src_t ex_fwd,
    input  wire fwd_src_t me_fwd,
    input  wire fwd_src_t wb_fwd,
    input  wire           ex_is_load,
    output word_t         rj_value,
    output word_t         rkd_value,
    output reg_idx_t      rf_raddr2,
    output logic          ld_stall
);

    reg_idx_t src2;
    logic     use_src2;

    // Youngest producer wins.
    function automatic word_t pick(reg_idx_t src, logic used, word_t rf_value,
                                   fwd_src_t ex, fwd_src_t me, fwd_src_t wb);
        if (!used || src == '0) begin
            return rf_value;
        end else if (ex.dest == src) begin
            return ex.value;
        end else if (me.dest == src) begin
            return me.value;
        end else if (wb.dest == src) begin
            return wb.value;
        end
        return rf_value;
    endfunction

    assign src2      = use_rd ? rd : rk;
    assign use_src2  = use_rd || use_rk;
    assign rf_raddr2 = src2;

    assign rj_value  = pick(rj, use_rj, rf_rdata1, ex_fwd, me_fwd, wb_fwd);
    assign rkd_value = pick(src2, use_src2, rf_rdata2, ex_fwd, me_fwd, wb_fwd);

    // Load data is not ready until MEM.
    assign ld_stall = ex_is_load && ex_fwd.dest != '0 &&
                      ((use_rj && rj == ex_fwd.dest) || (use_src2 && src2 == ex_fwd.dest));

endmodule

`default_nettype wire

//--- hw/regfile.sv
`timescale 1ns/10ps
`default_nettype none

module regfile
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  wire           clk,
    input  wire           reset,
    input  wire reg_idx_t raddr1,
    input  wire reg_idx_t raddr2,
    output word_t         rdata1,
    output word_t         rdata2,
    input  wire wb_rf_t   wr
);

    word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.we && wr.addr != '0) begin   // r0 is hardwired.
            regs[wr.addr] <= wr.data;
        end
    end

    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

    r0_reads_zero: assert property (@(posedge clk) disable iff (reset)
        (raddr1 != '0 || rdata1 == '0) && (raddr2 != '0 || rdata2 == '0));

endmodule

`default_nettype wire

//--- project.f
+incdir+tb
common/isa_pkg.sv
common/pipe_pkg.sv
hw/regfile.sv
hw/operand_forward.sv
hw/branch_unit.sv
decode/inst_decoder.sv
decode/id_stage.sv
tb/tb_id_stage.sv

//--- tb/id_ref.svh
`ifndef ID_REF_SVH
`define ID_REF_SVH

typedef struct packed {
    ctrl_t    ctrl;
    word_t    imm;
    word_t    offs;
    br_kind_t kind;
    logic     use_rj;
    logic     use_2;
    reg_idx_t src2;
} ref_t;

function automatic ref_t ref_decode(logic [31:0] w);
    ref_t r;
    logic [16:0] op17;
    logic [9:0] op10;
    op17 = w[31:15];
    op10 = w[31:22];
    r = '0;
    r.ctrl.dest = w[4:0];
    r.ctrl.gr_we = 1'b1;
    r.use_rj = 1'b1;
    r.src2 = w[14:10];
    r.imm = {{20{w[21]}}, w[21:10]};
    r.offs = {{14{w[25]}}, w[25:10], 2'b00};
    case (op17)
        OP17_ADD_W:  r.ctrl.alu_op[ALU_ADD] = 1'b1;
        OP17_SUB_W:  r.ctrl.alu_op[ALU_SUB] = 1'b1;
        OP17_SLT:    r.ctrl.alu_op[ALU_SLT] = 1'b1;
        OP17_SLTU:   r.ctrl.alu_op[ALU_SLTU] = 1'b1;
        OP17_NOR:    r.ctrl.alu_op[ALU_NOR] = 1'b1;
        OP17_AND:    r.ctrl.alu_op[ALU_AND] = 1'b1;
        OP17_OR:     r.ctrl.alu_op[ALU_OR] = 1'b1;
        OP17_XOR:    r.ctrl.alu_op[ALU_XOR] = 1'b1;
        OP17_SLL_W:  r.ctrl.alu_op[ALU_SLL] = 1'b1;
        OP17_SRL_W:  r.ctrl.alu_op[ALU_SRL] = 1'b1;
        OP17_SRA_W:  r.ctrl.alu_op[ALU_SRA] = 1'b1;
        OP17_SLLI_W: r.ctrl.alu_op[ALU_SLL] = 1'b1;
        OP17_SRLI_W: r.ctrl.alu_op[ALU_SRL] = 1'b1;
        OP17_SRAI_W: r.ctrl.alu_op[ALU_SRA] = 1'b1;
        default: ;
    endcase
    if (r.ctrl.alu_op != '0) begin
        if (op17 == OP17_SLLI_W || op17 == OP17_SRLI_W || op17 == OP17_SRAI_W) begin
            r.ctrl.src2_is_imm = 1'b1;
            r.imm = {27'b0, w[14:10]};
        end else begin
            r.use_2 = 1'b1;
        end
        return r;
    end
    r.ctrl.src2_is_imm = 1'b1;
    case (op10)
        OP10_ADDI_W: r.ctrl.alu_op[ALU_ADD] = 1'b1;
        OP10_SLTI:   r.ctrl.alu_op[ALU_SLT] = 1'b1;
        OP10_SLTUI:  r.ctrl.alu_op[ALU_SLTU] = 1'b1;
        OP10_ANDI:   r.ctrl.alu_op[ALU_AND] = 1'b1;
        OP10_ORI:    r.ctrl.alu_op[ALU_OR] = 1'b1;
        OP10_XORI:   r.ctrl.alu_op[ALU_XOR] = 1'b1;
        default: ;
    endcase
    if (op10 == OP10_ANDI || op10 == OP10_ORI || op10 == OP10_XORI) begin
        r.imm = {20'b0, w[21:10]};   // Logical ops zero-extend.
    end
    if (r.ctrl.alu_op != '0) begin
        return r;
    end
    if (op10 inside {OP10_LD_B, OP10_LD_H, OP10_LD_W, OP10_LD_BU, OP10_LD_HU}) begin
        r.ctrl.alu_op[ALU_ADD] = 1'b1;
        r.ctrl.load_op = 1'b1;
        r.ctrl.mem_is_byte = op10 == OP10_LD_B || op10 == OP10_LD_BU;
        r.ctrl.mem_is_half = op10 == OP10_LD_H || op10 == OP10_LD_HU;
        r.ctrl.mem_is_word = op10 == OP10_LD_W;
        r.ctrl.src_is_signed = op10 == OP10_LD_B || op10 == OP10_LD_H;
        return r;
    end
    if (op10 inside {OP10_ST_B, OP10_ST_H, OP10_ST_W}) begin
        r.ctrl.alu_op[ALU_ADD] = 1'b1;
        r.ctrl.store_op = 1'b1;
        r.ctrl.gr_we = 1'b0;
        r.ctrl.mem_is_byte = op10 == OP10_ST_B;
        r.ctrl.mem_is_half = op10 == OP10_ST_H;
        r.ctrl.mem_is_word = op10 == OP10_ST_W;
        r.ctrl.mem_we = (op10 == OP10_ST_W) ? 4'b1111 : (op10 == OP10_ST_H) ? 4'b0011 : 4'b0001;
        r.use_2 = 1'b1;
        r.src2 = w[4:0];
        return r;
    end
    if (w[31:25] == OP7_LU12I || w[31:25] == OP7_PCADDU12I) begin
        r.ctrl.alu_op[ALU_LUI] = w[31:25] == OP7_LU12I;
        r.ctrl.alu_op[ALU_ADD] = w[31:25] == OP7_PCADDU12I;
        r.ctrl.src1_is_pc = w[31:25] == OP7_PCADDU12I;
        r.use_rj = 1'b0;
        r.imm = {w[24:5], 12'b0};
        return r;
    end
    if (w[31:26] < OP6_BRANCH_JIRL || w[31:26] > OP6_BRANCH_BGEU) begin
        r = '0;
        r.ctrl.illegal = 1'b1;
        return r;
    end
    r.kind = br_kind_t'(w[31:26] - OP6_BRANCH_JIRL + 1);
    r.ctrl.src2_is_imm = 1'b0;
    if (r.kind == BR_JIRL || r.kind == BR_BL) begin
        r.ctrl.alu_op[ALU_ADD] = 1'b1;   // Link value is pc + 4.
        r.ctrl.src1_is_pc = 1'b1;
        r.ctrl.src2_is_imm = 1'b1;
        r.imm = 32'd4;
    end
    if (r.kind == BR_B || r.kind == BR_BL) begin
        r.use_rj = 1'b0;
        r.offs = {{4{w[9]}}, w[9:0], w[25:10], 2'b00};
    end
    if (r.kind == BR_BL) begin
        r.ctrl.dest = 5'd1;
    end
    if (r.kind == BR_B || r.kind >= BR_BEQ) begin
        r.ctrl.gr_we = 1'b0;
    end
    if (r.kind >= BR_BEQ) begin
        r.use_2 = 1'b1;
        r.src2 = w[4:0];
    end
    r.ctrl.src_is_signed = r.kind == BR_BLT || r.kind == BR_BGE;
    return r;
endfunction

// Oldest stage first, so the youngest write overrides.
function automatic word_t ref_operand(reg_idx_t src, logic used, word_t rf_value,
                                      fwd_src_t ex, fwd_src_t me, fwd_src_t wb);
    word_t v;
    v = rf_value;
    if (used && src != 5'd0) begin
        if (wb.dest == src) v = wb.value;
        if (me.dest == src) v = me.value;
        if (ex.dest == src) v = ex.value;
    end
    return v;
endfunction

function automatic logic ref_taken(br_kind_t kind, word_t a, word_t b);
    case (kind)
        BR_JIRL, BR_B, BR_BL: return 1'b1;
        BR_BEQ:  return a == b;
        BR_BNE:  return a != b;
        BR_BLT:  return $signed(a) < $signed(b);
        BR_BGE:  return $signed(a) >= $signed(b);
        BR_BLTU: return a < b;
        BR_BGEU: return a >= b;
        default: return 1'b0;
    endcase
endfunction

`endif

//--- tb/tb_id_stage.sv
`timescale 1ns/10ps
`default_nettype none

module tb_id_stage
    import isa_pkg::*;
    import pipe_pkg::*;
;

    `include "id_ref.svh"

    localparam int NUM_INSTS = 14 * 3 + 14 * 3 + 2 * 3 + 10 + 11 + 3 + 2 + 72 + 30;

    logic     clk;
    logic     reset;
    logic     if_valid;
    if_id_t   if_id;
    logic     id_allow_in;
    logic     id_ex_valid;
    id_ex_t   id_ex;
    logic     ex_allow_in;
    fwd_src_t ex_fwd, me_fwd, wb_fwd;
    logic     ex_is_load;
    wb_rf_t   wb_rf;
    br_t      br;

    word_t    shadow [NUM_REGS] = '{default: '0};
    if_id_t   exp_q [$];
    word_t    pc_next;
    int       checks = 0;
    int       errors = 0;

    logic [16:0] op17_list [14] = '{OP17_ADD_W, OP17_SUB_W, OP17_SLT, OP17_SLTU, OP17_NOR,
        OP17_AND, OP17_OR, OP17_XOR, OP17_SLL_W, OP17_SRL_W, OP17_SRA_W, OP17_SLLI_W,
        OP17_SRLI_W, OP17_SRAI_W};
    logic [9:0] op10_list [14] = '{OP10_SLTI, OP10_SLTUI, OP10_ADDI_W, OP10_ANDI, OP10_ORI,
        OP10_XORI, OP10_LD_B, OP10_LD_H, OP10_LD_W, OP10_ST_B, OP10_ST_H, OP10_ST_W,
        OP10_LD_BU, OP10_LD_HU};
    logic [6:0] op7_list [2] = '{OP7_LU12I, OP7_PCADDU12I};

    id_stage id_stage_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check(string what, logic [63:0] got, logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic issue(logic [31:0] inst);
        if_valid <= 1'b1;
        if_id <= {pc_next, inst};
        pc_next = pc_next + 4;
        @(posedge clk);
        while (!id_allow_in) @(posedge clk);
        if_valid <= 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) @(negedge clk);
        @(posedge clk);
    endtask

    function automatic logic [31:0] add_w(reg_idx_t rk, reg_idx_t rj, reg_idx_t rd);
        return {OP17_ADD_W, rk, rj, rd};
    endfunction

    always @(posedge clk) begin : compare
        if_id_t cur;
        ref_t   r;
        word_t  v1, v2;
        logic   stall, xfer, free, taken;
        if (!reset) begin
            free = 1'b1;
            taken = 1'b0;
            if (exp_q.size() == 0) begin
                check("id_ex_valid when empty", 64'(id_ex_valid), 64'(0));
                check("id_allow_in when empty", 64'(id_allow_in), 64'(1));
                check("br.taken when empty", 64'(br.taken), 64'(0));
            end else begin
                cur = exp_q[0];
                r = ref_decode(cur.inst);
                v1 = ref_operand(cur.inst[9:5], r.use_rj, shadow[cur.inst[9:5]],
                                 ex_fwd, me_fwd, wb_fwd);
                v2 = ref_operand(r.src2, r.use_2, shadow[r.src2], ex_fwd, me_fwd, wb_fwd);
                stall = ex_is_load && ex_fwd.dest != 0 &&
                        ((r.use_rj && cur.inst[9:5] == ex_fwd.dest) ||
                         (r.use_2 && r.src2 == ex_fwd.dest));
                xfer = !stall && ex_allow_in;
                free = xfer;
                check("id_ex_valid", 64'(id_ex_valid), 64'(!stall));
                check("id_allow_in when full", 64'(id_allow_in), 64'(xfer));
                if (xfer) begin
                    taken = ref_taken(r.kind, v1, v2);
                    check("ctrl", 64'(id_ex.ctrl), 64'(r.ctrl));
                    check("pc", 64'(id_ex.pc), 64'(cur.pc));
                    if (!r.ctrl.illegal) begin
                        check("imm", 64'(id_ex.imm), 64'(r.imm));
                        check("rj_value", 64'(id_ex.rj_value), 64'(v1));
                        check("rkd_value", 64'(id_ex.rkd_value), 64'(v2));
                    end
                    check("br.taken", 64'(br.taken), 64'(taken));
                    if (taken) begin
                        check("br.target", 64'(br.target),
                              64'(((r.kind == BR_JIRL) ? v1 : cur.pc) + r.offs));
                    end
                    void'(exp_q.pop_front());
                end else begin
                    check("br.taken while held", 64'(br.taken), 64'(0));
                end
            end
            if (if_valid && free && !taken) exp_q.push_back(if_id);
            if (wb_rf.we && wb_rf.addr != 0) shadow[wb_rf.addr] = wb_rf.data;
        end
    end

    initial begin : watchdog
        repeat (NUM_INSTS * 20 + 200) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", NUM_INSTS * 20 + 200);
        $display("Test FAILED");
        $finish;
    end

    initial begin : stimulus
        void'($urandom(62));
        reset = 1'b1;
        if_valid = 1'b0;
        if_id = '0;
        ex_allow_in = 1'b1;
        ex_fwd = '0;
        me_fwd = '0;
        wb_fwd = '0;
        ex_is_load = 1'b0;
        wb_rf = '0;
        pc_next = 32'h1c00_0000;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        // Decode of every kept opcode, then unknown words.
        foreach (op17_list[i]) repeat (3) issue({op17_list[i], 15'($urandom)});
        foreach (op10_list[i]) repeat (3) issue({op10_list[i], 22'($urandom)});
        foreach (op7_list[i]) repeat (3) issue({op7_list[i], 25'($urandom)});
        repeat (10) issue({6'h3f, 26'($urandom)});
        drain();

        // Register file writes, r0 included.
        repeat (20) begin
            wb_rf <= '{we: 1'b1, addr: 5'($urandom), data: $urandom};
            @(posedge clk);
        end
        wb_rf <= '{we: 1'b1, addr: 5'd0, data: $urandom};
        @(posedge clk);
        wb_rf <= '0;
        @(posedge clk);
        repeat (10) issue(add_w(5'($urandom), 5'($urandom), 5'($urandom)));
        issue(add_w(5'd0, 5'd0, 5'd3));
        drain();

        // Forwarding priority.
        ex_fwd <= '{dest: 5'd5, value: $urandom};
        me_fwd <= '{dest: 5'd5, value: $urandom};
        wb_fwd <= '{dest: 5'd5, value: $urandom};
        issue(add_w(5'd5, 5'd5, 5'd2));
        drain();
        ex_fwd <= '0;
        issue(add_w(5'd5, 5'd5, 5'd2));
        drain();
        me_fwd <= '0;
        issue(add_w(5'd5, 5'd5, 5'd2));
        drain();
        wb_fwd <= '0;

        // Load-use stall, then the same dest on an unused source.
        ex_fwd <= '{dest: 5'd7, value: $urandom};
        ex_is_load <= 1'b1;
        issue(add_w(5'd3, 5'd7, 5'd4));
        repeat (5) @(posedge clk);
        ex_is_load <= 1'b0;
        drain();
        ex_is_load <= 1'b1;
        issue({OP7_LU12I, 15'($urandom), 5'd7, 5'($urandom)});   // rj field names r7.
        drain();
        ex_is_load <= 1'b0;
        ex_fwd <= '0;

        // Branches, each followed by an instruction that must be dropped if taken.
        for (int k = 0; k < 9; k++) begin
            repeat (4) begin
                issue({6'(OP6_BRANCH_JIRL + k), 26'($urandom)});
                issue(add_w(5'($urandom), 5'($urandom), 5'($urandom)));
            end
        end
        drain();

        // Back-pressure.
        fork
            begin
                repeat (20) begin
                    ex_allow_in <= 1'($urandom);
                    repeat ($urandom_range(1, 4)) @(posedge clk);
                end
                ex_allow_in <= 1'b1;
            end
            repeat (30) issue({op17_list[$urandom % 11], 15'($urandom)});
        join
        ex_allow_in <= 1'b1;
        drain();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
